// ==== sim/memCtrl_vectors.txt ====
// columns: kind_addr_len_wdata_expected_flags, one access per line
// kind 0 fetch, 1 load, 2 store, 3 fetch and load together; flags 1 rdy pause, 2 IO buffer full
0_00001234_4_00000000_25242726_0
1_00002051_1_00000000_00000071_0
1_00000340_2_00000000_00004243_0
1_00000a10_4_00000000_19181b1a_0
2_00000500_2_deadbeef_00000000_0
1_00000500_4_00000000_0607beef_0
2_00000600_4_11223344_00000000_0
1_00000600_4_00000000_11223344_0
2_00000700_1_000000ab_00000000_0
1_00000700_2_00000000_000006ab_0
3_00000800_4_00000000_0b0a0908_0
0_00001000_4_00000000_13121110_1
1_00000600_4_00000000_11223344_1
2_00000900_4_cafef00d_00000000_1
1_00000900_4_00000000_cafef00d_0
2_00030010_4_89abcdef_89abcdef_2
2_00030020_2_00005a5a_00005a5a_0

// ==== filelist.f ====
+incdir+include
src/memCtrl_pkg.sv
src/fetchUnit.sv
src/dataUnit.sv
src/memArbiter.sv
src/memCtrl.sv
sim/memCtrl_properties.sv
sim/memCtrl_tb.sv

// ==== Bender.yml ====
package:
  name: memctrl

sources:
  - include_dirs:
      - include
    files:
      - src/memCtrl_pkg.sv
      - src/fetchUnit.sv
      - src/dataUnit.sv
      - src/memArbiter.sv
      - src/memCtrl.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/memCtrl_properties.sv
      - sim/memCtrl_tb.sv

// ==== sim/memCtrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "memCtrl_cfg.svh"

module memCtrl_tb;
    import memCtrl_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  rdy;
    logic                  ioBufferFull;
    logic                  infEn;
    logic [`MC_ADDR_W-1:0] infAddr;
    logic                  infDone;
    logic [`MC_INST_W-1:0] infInst;
    logic                  dcEn;
    memOp_e                dcOp;
    logic [2:0]            dcLen;
    logic [`MC_ADDR_W-1:0] dcAddr;
    logic [`MC_DATA_W-1:0] dcWdata;
    logic                  dcDone;
    logic [`MC_DATA_W-1:0] dcRdata;
    logic [7:0]            memDin;
    logic [`MC_ADDR_W-1:0] memAddr;
    logic                  memWr;
    logic [7:0]            memDout;
    owner_e                owner;

    logic [7:0]   ram [0:65535];
    logic [7:0]   ioLog [$];
    int           wrCount;
    // kind, addr, len, wdata, expected, flags
    logic [107:0] vecs [0:63];
    int           numVec;

    memCtrl dut0 (
        .clk (clk), .rst (rst), .rdy (rdy), .ioBufferFull (ioBufferFull),
        .infEn (infEn), .infAddr (infAddr), .infDone (infDone), .infInst (infInst),
        .dcEn (dcEn), .dcOp (dcOp), .dcLen (dcLen), .dcAddr (dcAddr),
        .dcWdata (dcWdata), .dcDone (dcDone), .dcRdata (dcRdata),
        .memDin (memDin), .memAddr (memAddr), .memWr (memWr),
        .memDout (memDout), .owner (owner)
    );

    always #20 clk = ~clk;

    // byte RAM, read data one cycle after the address
    always @(posedge clk) begin
        if (memWr) begin
            wrCount = wrCount + 1;
            if (memAddr >= `MC_IO_BASE) ioLog.push_back(memDout);
            else ram[memAddr[15:0]] <= memDout;
        end
        memDin <= ram[memAddr[15:0]];
    end

    task automatic failNow();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, got);
            failNow();
        end
    endtask

    task automatic runVector(input logic [107:0] v);
        logic [3:0]  kind;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [31:0] expVal;
        logic [3:0]  flags;
        logic        gotF;
        logic        gotD;
        int          n;
        int          fAt;
        int          dAt;
        int          pauseAt;
        int          pauseLen;
        int          holdLen;
        int          logBase;
        int          b;
        kind     = v[107:104];
        addr     = v[103:72];
        len      = v[71:68];
        expVal   = v[35:4];
        flags    = v[3:0];
        pauseAt  = $urandom_range(2, 1);
        pauseLen = $urandom_range(4, 1);
        holdLen  = $urandom_range(5, 2);
        @(posedge clk);
        #2;
        wrCount = 0;
        logBase = ioLog.size();
        gotF    = !(kind == 4'd0 || kind == 4'd3);
        gotD    = (kind == 4'd0);
        infAddr = addr;
        infEn   = !gotF;
        dcOp    = (kind == 4'd2) ? opStore : opLoad;
        dcLen   = len[2:0];
        dcAddr  = addr;
        dcWdata = v[67:36];
        dcEn    = !gotD;
        ioBufferFull = flags[1];
        n = 0;
        while (!(gotF && gotD)) begin
            @(negedge clk);
            if (!rdy) begin
                assert (!infDone && !dcDone && !memWr) else begin
                    $display("done pulse or RAM write while rdy was low at %0t", $time);
                    failNow();
                end
            end
            if (ioBufferFull) begin
                assert (wrCount == 0 && !dcDone) else begin
                    $display("IO store went ahead while ioBufferFull was high");
                    failNow();
                end
            end
            if (infDone && !gotF) begin
                gotF = 1'b1;
                fAt  = n;
                checkValue("infInst", expVal, infInst);
            end
            if (dcDone && !gotD) begin
                gotD = 1'b1;
                dAt  = n;
                if (kind != 4'd2) checkValue("dcRdata", expVal, dcRdata);
            end
            @(posedge clk);
            #2;
            n++;
            if (gotF) infEn = 1'b0;
            if (gotD) dcEn = 1'b0;
            if (flags[0] && n == pauseAt) rdy = 1'b0;
            if (flags[0] && n == pauseAt + pauseLen) rdy = 1'b1;
            if (flags[1] && n == holdLen) ioBufferFull = 1'b0;
        end
        // bus is free again once the last access has finished
        checkValue("owner", ownNone, owner);
        // latency counted from the cycle the enable was first driven
        if (flags == 4'd0 && kind == 4'd0) checkValue("infDone cycle", 6, fAt);
        if (flags == 4'd0 && kind == 4'd1) checkValue("dcDone cycle", 2 + len, dAt);
        if (flags == 4'd0 && kind == 4'd2) checkValue("dcDone cycle", 1 + len, dAt);
        if (kind == 4'd3) begin
            assert (dAt < fAt) else begin
                $display("dcDone did not come before infDone in the contended access");
                failNow();
            end
        end
        checkValue("memWr count", (kind == 4'd2) ? len : 0, wrCount);
        if (kind == 4'd2 && addr >= `MC_IO_BASE) begin
            checkValue("ioLog size", logBase + len, ioLog.size());
            for (b = 0; b < len; b++) begin
                checkValue("ioLog byte", expVal[8*b +: 8], ioLog[logBase + b]);
            end
        end
    endtask

    initial begin
        #1;
        repeat (numVec * 40 + 8) @(posedge clk);
        $display("watchdog expired before all vectors finished");
        failNow();
    end

    initial begin
        int i;
        void'($urandom(32'h4329_ee46));
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        infEn        = 1'b0;
        infAddr      = '0;
        dcEn         = 1'b0;
        dcOp         = opLoad;
        dcLen        = '0;
        dcAddr       = '0;
        dcWdata      = '0;
        memDin       = '0;
        wrCount      = 0;
        // fill depends on all 16 index bits
        for (i = 0; i < 65536; i++) ram[i] = i[7:0] ^ i[15:8];
        for (i = 0; i < 64; i++) vecs[i] = '1;
        $readmemh("sim/memCtrl_vectors.txt", vecs);
        numVec = 0;
        while (numVec < 64 && vecs[numVec] !== '1) numVec++;
        assert (numVec > 0) else begin
            $display("no vectors were read from sim/memCtrl_vectors.txt");
            failNow();
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // idle outputs right after reset
        checkValue("owner", ownNone, owner);
        checkValue("infDone", 0, infDone);
        checkValue("dcDone", 0, dcDone);
        checkValue("memWr", 0, memWr);
        for (i = 0; i < numVec; i++) begin
            repeat ($urandom_range(3, 0)) @(posedge clk);
            runVector(vecs[i]);
        end
        repeat (3) @(posedge clk);
        if (dut0.props0.failCount == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("bound property checks failed %0d times", dut0.props0.failCount);
            failNow();
        end
    end

endmodule

`default_nettype wire

// ==== sim/memCtrl_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module memCtrl_properties (
    input logic                clk,
    input logic                rst,
    input logic                memWr,
    input logic                infDone,
    input logic                dcDone,
    input logic                fetchGrant,
    input logic                dataGrant,
    input memCtrl_pkg::owner_e owner
);
    import memCtrl_pkg::*;

    // failed properties so far
    int failCount = 0;

    // only the data unit writes the RAM
    wrByData: assert property (@(posedge clk) disable iff (rst) memWr |-> owner == ownData)
        else begin
            failCount++;
            $error("memWr high while owner is not ownData");
        end

    infPulse: assert property (@(posedge clk) disable iff (rst) infDone |=> !infDone)
        else begin
            failCount++;
            $error("infDone high for more than one cycle");
        end

    dcPulse: assert property (@(posedge clk) disable iff (rst) dcDone |=> !dcDone)
        else begin
            failCount++;
            $error("dcDone high for more than one cycle");
        end

    noGrantInReset: assert property (@(posedge clk) rst |=> !(fetchGrant || dataGrant))
        else begin
            failCount++;
            $error("grant seen during reset");
        end

endmodule

bind memCtrl memCtrl_properties props0 (
    .clk        (clk),
    .rst        (rst),
    .memWr      (memWr),
    .infDone    (infDone),
    .dcDone     (dcDone),
    .fetchGrant (fetchGrant),
    .dataGrant  (dataGrant),
    .owner      (owner)
);

`default_nettype wire

// ==== src/memCtrl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "memCtrl_cfg.svh"

module memCtrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  ioBufferFull,
    // instruction fetch client
    input  logic                  infEn,
    input  logic [`MC_ADDR_W-1:0] infAddr,
    output logic                  infDone,
    output logic [`MC_INST_W-1:0] infInst,
    // data client
    input  logic                  dcEn,
    input  memCtrl_pkg::memOp_e   dcOp,
    input  logic [2:0]            dcLen,
    input  logic [`MC_ADDR_W-1:0] dcAddr,
    input  logic [`MC_DATA_W-1:0] dcWdata,
    output logic                  dcDone,
    output logic [`MC_DATA_W-1:0] dcRdata,
    // byte-wide RAM
    input  logic [7:0]            memDin,
    output logic [`MC_ADDR_W-1:0] memAddr,
    output logic                  memWr,
    output logic [7:0]            memDout,
    output memCtrl_pkg::owner_e   owner
);
    logic                  fetchReq;
    logic                  fetchGrant;
    logic [`MC_ADDR_W-1:0] fetchAddr;
    logic                  dataReq;
    logic                  dataGrant;
    logic [`MC_ADDR_W-1:0] dataAddr;
    logic                  dataWr;
    logic [7:0]            dataWbyte;
    logic [7:0]            memByte;

    fetchUnit fetch0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .infEn      (infEn),
        .infAddr    (infAddr),
        .fetchGrant (fetchGrant),
        .memByte    (memByte),
        .infDone    (infDone),
        .infInst    (infInst),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr)
    );

    dataUnit data0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dcEn         (dcEn),
        .dcOp         (dcOp),
        .dcLen        (dcLen),
        .dcAddr       (dcAddr),
        .dcWdata      (dcWdata),
        .dataGrant    (dataGrant),
        .memByte      (memByte),
        .dcDone       (dcDone),
        .dcRdata      (dcRdata),
        .dataReq      (dataReq),
        .dataAddr     (dataAddr),
        .dataWr       (dataWr),
        .dataWbyte    (dataWbyte)
    );

    memArbiter arb0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .dataReq    (dataReq),
        .dataAddr   (dataAddr),
        .dataWr     (dataWr),
        .dataWbyte  (dataWbyte),
        .memDin     (memDin),
        .fetchGrant (fetchGrant),
        .dataGrant  (dataGrant),
        .memByte    (memByte),
        .memAddr    (memAddr),
        .memWr      (memWr),
        .memDout    (memDout),
        .owner      (owner)
    );

endmodule

`default_nettype wire

// ==== src/memArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "memCtrl_cfg.svh"

module memArbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  fetchReq,
    input  logic [`MC_ADDR_W-1:0] fetchAddr,
    input  logic                  dataReq,
    input  logic [`MC_ADDR_W-1:0] dataAddr,
    input  logic                  dataWr,
    input  logic [7:0]            dataWbyte,
    input  logic [7:0]            memDin,
    output logic                  fetchGrant,
    output logic                  dataGrant,
    output logic [7:0]            memByte,
    output logic [`MC_ADDR_W-1:0] memAddr,
    output logic                  memWr,
    output logic [7:0]            memDout,
    output memCtrl_pkg::owner_e   owner
);
    import memCtrl_pkg::*;

    owner_e                nextOwner;
    logic                  ownerReq;
    logic [`MC_ADDR_W-1:0] busAddr;
    logic [`MC_ADDR_W-1:0] lastAddr;

    always_comb begin
        case (owner)
            ownFetch: ownerReq = fetchReq;
            ownData:  ownerReq = dataReq;
            default:  ownerReq = 1'b0;
        endcase
        // keep the bus until the holder lets go, then data first
        if (ownerReq) begin
            nextOwner = owner;
        end else if (dataReq) begin
            nextOwner = ownData;
        end else if (fetchReq) begin
            nextOwner = ownFetch;
        end else begin
            nextOwner = ownNone;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownNone;
        end else if (rdy) begin
            owner <= nextOwner;
        end
    end

    always_comb begin
        case (owner)
            ownFetch: busAddr = fetchAddr;
            ownData:  busAddr = dataAddr;
            default:  busAddr = '0;
        endcase
    end

    // replay the last read address while frozen so the byte in flight survives
    always_ff @(posedge clk) begin
        if (rdy) begin
            lastAddr <= busAddr;
        end
    end

    assign memAddr    = rdy ? busAddr : lastAddr;
    assign memWr      = rdy && dataWr;
    assign memDout    = (owner == ownData) ? dataWbyte : 8'h00;
    assign memByte    = memDin;
    assign fetchGrant = (owner == ownFetch);
    assign dataGrant  = (owner == ownData);

endmodule

`default_nettype wire

// ==== src/dataUnit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "memCtrl_cfg.svh"

module dataUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  ioBufferFull,
    input  logic                  dcEn,
    input  memCtrl_pkg::memOp_e   dcOp,
    input  logic [2:0]            dcLen,
    input  logic [`MC_ADDR_W-1:0] dcAddr,
    input  logic [`MC_DATA_W-1:0] dcWdata,
    input  logic                  dataGrant,
    input  logic [7:0]            memByte,
    output logic                  dcDone,
    output logic [`MC_DATA_W-1:0] dcRdata,
    output logic                  dataReq,
    output logic [`MC_ADDR_W-1:0] dataAddr,
    output logic                  dataWr,
    output logic [7:0]            dataWbyte
);
    import memCtrl_pkg::*;

    unitState_e            state;
    memOp_e                opReg;
    logic [`MC_ADDR_W-1:0] baseAddr;
    logic [`MC_DATA_W-1:0] wdataReg;
    logic [`MC_DATA_W-1:0] rdataReg;
    logic [2:0]            lenReg;
    logic [2:0]            issueCnt;
    logic [2:0]            rcvCnt;
    logic                  pend;
    logic                  ioHold;
    logic                  start;
    logic                  running;
    logic                  issue;

    // IO store waits here while the output buffer is full
    assign ioHold  = (dcOp == opStore) && (dcAddr >= `MC_IO_BASE) && ioBufferFull;
    assign start   = dcEn && !ioHold;
    assign running = (state == usRun) && (issueCnt != lenReg);
    assign issue   = running && dataGrant;

    assign dataReq   = (state == usIdle) ? start : running;
    assign dataAddr  = baseAddr + `MC_ADDR_W'(issueCnt);
    assign dataWr    = issue && (opReg == opStore);
    assign dataWbyte = wdataReg[{issueCnt[1:0], 3'b000} +: 8];
    assign dcDone    = (state == usDone);
    assign dcRdata   = rdataReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= usIdle;
            issueCnt <= '0;
            rcvCnt   <= '0;
            pend     <= 1'b0;
        end else if (rdy) begin
            pend <= issue && (opReg == opLoad);
            case (state)
                usIdle: begin
                    issueCnt <= '0;
                    rcvCnt   <= '0;
                    if (start) begin
                        state <= usRun;
                    end
                end
                usRun: begin
                    if (issue) begin
                        issueCnt <= issueCnt + 3'd1;
                        // store ends with its last write
                        if ((opReg == opStore) && ((issueCnt + 3'd1) == lenReg)) begin
                            state <= usDone;
                        end
                    end
                    if (pend) begin
                        rcvCnt <= rcvCnt + 3'd1;
                        if ((rcvCnt + 3'd1) == lenReg) begin
                            state <= usDone;
                        end
                    end
                end
                usDone: begin
                    state <= usIdle;
                end
                default: begin
                    state <= usIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if ((state == usIdle) && start) begin
                opReg    <= dcOp;
                lenReg   <= dcLen;
                baseAddr <= dcAddr;
                wdataReg <= dcWdata;
                // upper bytes stay zero for short loads
                rdataReg <= '0;
            end else if (pend) begin
                rdataReg[{rcvCnt[1:0], 3'b000} +: 8] <= memByte;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "memCtrl_cfg.svh"

module fetchUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  infEn,
    input  logic [`MC_ADDR_W-1:0] infAddr,
    input  logic                  fetchGrant,
    input  logic [7:0]            memByte,
    output logic                  infDone,
    output logic [`MC_INST_W-1:0] infInst,
    output logic                  fetchReq,
    output logic [`MC_ADDR_W-1:0] fetchAddr
);
    import memCtrl_pkg::*;

    unitState_e            state;
    logic [`MC_ADDR_W-1:0] baseAddr;
    logic [`MC_INST_W-1:0] instReg;
    logic [2:0]            issueCnt;
    logic [1:0]            rcvCnt;
    logic                  pend;
    logic                  served;
    logic                  start;
    logic                  issue;

    // a served request starts again only once infEn drops or the address moves
    assign start = infEn && !(served && (infAddr == baseAddr));
    assign issue = (state == usRun) && fetchGrant && (issueCnt != 3'd4);

    assign fetchReq  = (state == usIdle) ? start : ((state == usRun) && (issueCnt != 3'd4));
    assign fetchAddr = baseAddr + `MC_ADDR_W'(issueCnt);
    assign infDone   = (state == usDone);
    assign infInst   = instReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= usIdle;
            issueCnt <= '0;
            rcvCnt   <= '0;
            pend     <= 1'b0;
            served   <= 1'b0;
        end else if (rdy) begin
            // byte addressed now comes back next cycle
            pend <= issue;
            case (state)
                usIdle: begin
                    issueCnt <= '0;
                    rcvCnt   <= '0;
                    if (!infEn || (infAddr != baseAddr)) begin
                        served <= 1'b0;
                    end
                    if (start) begin
                        state <= usRun;
                    end
                end
                usRun: begin
                    if (issue) begin
                        issueCnt <= issueCnt + 3'd1;
                    end
                    if (pend) begin
                        rcvCnt <= rcvCnt + 2'd1;
                        if (rcvCnt == 2'd3) begin
                            state  <= usDone;
                            served <= 1'b1;
                        end
                    end
                end
                usDone: begin
                    state <= usIdle;
                end
                default: begin
                    state <= usIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if ((state == usIdle) && start) begin
                baseAddr <= infAddr;
            end
            // little-endian, lowest byte arrives first
            if (pend) begin
                instReg <= {memByte, instReg[`MC_INST_W-1:8]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/memCtrl_pkg.sv ====
`default_nettype none

package memCtrl_pkg;

    // data access kind
    typedef enum logic {
        opLoad,
        opStore
    } memOp_e;

    // current holder of the RAM bus
    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } owner_e;

    // sequencer states, shared by both units
    typedef enum logic [1:0] {
        usIdle,
        usRun,
        usDone
    } unitState_e;

endpackage

`default_nettype wire

// ==== include/memCtrl_cfg.svh ====
`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// byte address width
`define MC_ADDR_W 32

// fetched instruction word
`define MC_INST_W 32

// load and store data
`define MC_DATA_W 32

// addresses at or above this are IO
`define MC_IO_BASE 32'h0003_0000

`endif
